/* dcache.f */
+incdir+source
source/dcache_pkg.sv
source/cache_fill_fsm.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/dcache.sv
verif/mem_model.sv
verif/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dcache_tb -f dcache.f -o dcache_sim > sim.log 2>&1 &&
	./obj_dir/dcache_sim >> sim.log 2>&1
grep -q "^ALL CHECKS PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb
	import dcache_pkg::*;
();

	localparam int mem_latency = 3; // read latency of the memory model in cycles
	localparam int cycle_limit = 12000; // about 330 requests at 20 cycles per miss, plus margin
	localparam int random_ops = 300;

	logic clk;
	logic arst_n;
	cpu_req_t cpu_req;
	logic [`DATA_W-1:0] rdata;
	logic rdata_valid;
	logic stall;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	// expectations change 1 ns after a rising edge, so they are settled at the falling edge
	logic req_seen; // some request was driven since reset
	logic first_cycle; // the current cycle is the first one of a request
	logic pred_hit; // the local tag model says the request hits
	logic [`ADDR_W-1:0] exp_base; // block base that a miss has to fetch
	logic [`ADDR_W-1:0] exp_fill_addr; // address that the current fill read must carry
	int fill_reads; // fill reads seen so far in the current fill
	logic exp_rvalid; // a read was accepted in the previous cycle
	logic [`DATA_W-1:0] exp_rdata; // word that read must return
	logic [`DATA_W-1:0] shadow [logic [`ADDR_W-1:0]]; // own writes, keyed by word address
	logic [`TAG_W-1:0] model_tag [`NUM_SETS];
	logic [`NUM_SETS-1:0] model_valid;
	int cycles = 0;

	dcache UUT (
		.clk(clk),
		.arst_n(arst_n),
		.cpu_req(cpu_req),
		.rdata(rdata),
		.rdata_valid(rdata_valid),
		.stall(stall),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	mem_model #(.latency(mem_latency)) mem (
		.clk(clk),
		.arst_n(arst_n),
		.req(mem_req),
		.rsp(mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// the run cannot outlive the longest expected test
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			abort_run("timeout: requests did not complete");
		end
	end

	// ****************************************
	// helpers
	// ****************************************

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		abort_run($sformatf("Error at %0t: %s expected %0h got %0h", $time, name, expected, actual));
	endtask

	function automatic cache_addr_t make_addr(input logic [`TAG_W-1:0] tag,
			input logic [`INDEX_W-1:0] index, input logic [`WORD_SEL_W-1:0] word_sel);
		cache_addr_t a;
		a.tag = tag;
		a.index = index;
		a.offset = {word_sel, 1'b0}; // words are always aligned
		return a;
	endfunction

	// memory pattern is the word address xor 5a5a unless the testbench wrote the word
	function automatic logic [`DATA_W-1:0] shadow_word(input logic [`ADDR_W-1:0] addr);
		logic [`ADDR_W-1:0] w;
		w = {1'b0, addr[`ADDR_W-1:1]};
		if (shadow.exists(w)) begin
			return shadow[w];
		end
		return w ^ 16'h5a5a;
	endfunction

	// advance to 1 ns after the next rising edge and drop single cycle expectations
	task automatic next_cycle();
		@(posedge clk);
		#1;
		exp_rvalid = 1'b0;
		first_cycle = 1'b0;
		if (mem_req.rd) begin
			exp_fill_addr = exp_base + 16'(fill_reads * 2); // reads walk the block in order
			fill_reads = fill_reads + 1;
		end
	endtask

	// one processor request held until the cache accepts it
	task automatic access(input logic is_write, input cache_addr_t addr,
			input logic [`DATA_W-1:0] data);
		cpu_req.rd = !is_write;
		cpu_req.wr = is_write;
		cpu_req.addr = addr;
		cpu_req.wdata = data;
		req_seen = 1'b1;
		first_cycle = 1'b1;
		pred_hit = model_valid[addr.index] && (model_tag[addr.index] == addr.tag);
		exp_base = {addr.tag, addr.index, 4'h0};
		fill_reads = 0;
		@(negedge clk);
		while (stall) begin
			next_cycle(); // global cycle counter catches a stall that never ends
			@(negedge clk);
		end
		next_cycle(); // edge that completes the request
		model_valid[addr.index] = 1'b1; // a miss has filled the block by now
		model_tag[addr.index] = addr.tag;
		if (is_write) begin
			shadow[{1'b0, addr[`ADDR_W-1:1]}] = data;
		end else begin
			exp_rvalid = 1'b1;
			exp_rdata = shadow_word(addr);
		end
		cpu_req.rd = 1'b0;
		cpu_req.wr = 1'b0;
	endtask

	// ****************************************
	// checks at the falling edge
	// ****************************************

	idle_after_reset: assert property (@(negedge clk) disable iff (!arst_n)
		!req_seen |-> !(stall || rdata_valid || mem_req.rd || mem_req.wr))
		else value_error("{stall, rdata_valid, mem_req.rd, mem_req.wr}", 64'h0,
			64'({stall, rdata_valid, mem_req.rd, mem_req.wr}));
	hit_or_miss: assert property (@(negedge clk) disable iff (!arst_n)
		first_cycle |-> stall == !pred_hit)
		else value_error("stall", 64'(!pred_hit), 64'(stall));
	hit_no_read: assert property (@(negedge clk) disable iff (!arst_n)
		first_cycle && pred_hit |-> !mem_req.rd)
		else value_error("mem_req.rd", 64'h0, 64'(mem_req.rd));
	fill_starts: assert property (@(negedge clk) disable iff (!arst_n)
		$past(first_cycle && !pred_hit) |-> mem_req.rd)
		else value_error("mem_req.rd", 64'h1, 64'(mem_req.rd));
	fill_cause: assert property (@(negedge clk) disable iff (!arst_n)
		mem_req.rd && !$past(mem_req.rd) |-> $past(first_cycle && !pred_hit))
		else abort_run("memory read started without a cache miss");
	fill_runs: assert property (@(negedge clk) disable iff (!arst_n)
		$past(mem_req.rd && fill_reads < `WORDS_PER_BLOCK) |-> mem_req.rd)
		else value_error("mem_req.rd", 64'h1, 64'(mem_req.rd));
	fill_stops: assert property (@(negedge clk) disable iff (!arst_n)
		mem_req.rd |-> fill_reads <= `WORDS_PER_BLOCK)
		else abort_run("a fill issued more than eight reads");
	fill_address: assert property (@(negedge clk) disable iff (!arst_n)
		mem_req.rd |-> mem_req.addr == exp_fill_addr)
		else value_error("mem_req.addr", 64'(exp_fill_addr), 64'(mem_req.addr));
	read_valid: assert property (@(negedge clk) disable iff (!arst_n)
		rdata_valid == exp_rvalid)
		else value_error("rdata_valid", 64'(exp_rvalid), 64'(rdata_valid));
	read_data: assert property (@(negedge clk) disable iff (!arst_n)
		rdata_valid |-> rdata == exp_rdata)
		else value_error("rdata", 64'(exp_rdata), 64'(rdata));
	// an accepted write goes to memory in its own cycle with its address and data
	write_through: assert property (@(negedge clk) disable iff (!arst_n)
		cpu_req.wr && !stall |-> mem_req == {1'b0, 1'b1, cpu_req.addr, cpu_req.wdata})
		else value_error("mem_req", 64'({1'b0, 1'b1, cpu_req.addr, cpu_req.wdata}), 64'(mem_req));
	write_cause: assert property (@(negedge clk) disable iff (!arst_n)
		mem_req.wr |-> cpu_req.wr && !stall)
		else abort_run("memory write without an accepted write request");

	// ****************************************
	// stimulus
	// ****************************************

	initial begin
		logic is_write;
		cache_addr_t addr;
		void'($urandom(32'h1f93ab08));
		arst_n = 1'b0;
		cpu_req = '0;
		req_seen = 1'b0;
		first_cycle = 1'b0;
		pred_hit = 1'b0;
		exp_base = '0;
		exp_fill_addr = '0;
		fill_reads = 0;
		exp_rvalid = 1'b0;
		exp_rdata = '0;
		model_valid = '0;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		repeat (4) next_cycle(); // quiet cycles before the first request

		access(1'b0, make_addr(7'h11, 5'd3, 3'd2), '0); // cold read miss fills set 3
		access(1'b0, make_addr(7'h11, 5'd3, 3'd7), '0); // other word of the same block hits
		access(1'b0, make_addr(7'h11, 5'd3, 3'd2), '0);
		access(1'b1, make_addr(7'h11, 5'd3, 3'd2), 16'hbeef); // write hit goes straight to memory
		access(1'b0, make_addr(7'h11, 5'd3, 3'd2), '0);
		access(1'b1, make_addr(7'h22, 5'd9, 3'd5), 16'h1234); // write miss fills first
		access(1'b0, make_addr(7'h22, 5'd9, 3'd5), '0);
		access(1'b0, make_addr(7'h33, 5'd3, 3'd0), '0); // evicts the block of tag 11
		access(1'b0, make_addr(7'h11, 5'd3, 3'd2), '0); // misses again and must bring back beef

		// four tags over all sets keep both hits and conflict misses frequent
		for (int i = 0; i < random_ops; i++) begin
			is_write = 1'($urandom % 2);
			addr = make_addr(7'h40 | 7'($urandom % 4), 5'($urandom % 32), 3'($urandom % 8));
			access(is_write, addr, 16'($urandom));
			if ($urandom % 4 == 0) begin
				next_cycle(); // gap with no request
			end
		end

		repeat (3) next_cycle(); // let the last read data be checked
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* verif/mem_model.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"

module mem_model
	import dcache_pkg::*;
#(
	parameter int latency = 3 // cycles from a read request to its data
) (
	input logic clk,
	input logic arst_n,
	input mem_req_t req, // at most one read or one write per cycle
	output mem_rsp_t rsp // one valid cycle per read, in request order
);

	logic [`DATA_W-1:0] store [logic [`ADDR_W-1:0]]; // written words, keyed by word address
	mem_rsp_t pipe [latency]; // one stage per cycle of latency

	// ****************************************
	// contents
	// ****************************************

	function automatic logic [`ADDR_W-1:0] word_of(input logic [`ADDR_W-1:0] addr);
		return {1'b0, addr[`ADDR_W-1:1]}; // the byte bit does not select a word
	endfunction

	// untouched words follow a pattern so that each word address reads back its own value
	function automatic logic [`DATA_W-1:0] read_word(input logic [`ADDR_W-1:0] addr);
		logic [`ADDR_W-1:0] w;
		w = word_of(addr);
		if (store.exists(w)) begin
			return store[w]; // a write has replaced the pattern
		end
		return w ^ 16'h5a5a;
	endfunction

	// ****************************************
	// request pipeline
	// ****************************************

	// read data is looked up when the request arrives and then just travels down the stages
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < latency; i++) begin
				pipe[i] <= '0;
			end
		end else begin
			pipe[0].valid <= req.rd;
			pipe[0].data <= read_word(req.addr);
			for (int i = 1; i < latency; i++) begin
				pipe[i] <= pipe[i-1]; // fixed latency with no back-pressure
			end
			if (req.wr) begin
				store[word_of(req.addr)] = req.wdata; // write through from the cache
			end
		end
	end

	assign rsp = pipe[latency-1]; // the last stage drives the response

endmodule

/* source/dcache.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache
	import dcache_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input cpu_req_t cpu_req, // held by the processor while stall is high

	output logic [`DATA_W-1:0] rdata, // read hit data, one cycle after acceptance
	output logic rdata_valid,
	output logic stall, // request cannot complete this cycle

	output mem_req_t mem_req, // fill reads and write through
	input mem_rsp_t mem_rsp // one pulse per returned word
);

	logic req_valid; // processor asks for something this cycle
	logic hit; // tag array says the block is present
	logic miss_detected; // live request that the tag array cannot serve
	logic accept; // request completes in this cycle
	logic rd_hit; // accepted read
	logic wr_hit; // accepted write, goes to the array and to memory

	logic fsm_busy;
	logic mem_read;
	cache_addr_t mem_read_addr;
	logic fill_we;
	logic [`OFFSET_W-1:0] fill_offset;
	logic write_tag;
	cache_addr_t base_addr;

	cache_addr_t fill_word_addr; // address of the word being filled
	logic arr_we; // data array write enable
	cache_addr_t arr_waddr; // data array write address
	logic [`DATA_W-1:0] arr_wdata; // data array write data

	// ****************************************
	// request decode
	// ****************************************

	assign req_valid = cpu_req.rd || cpu_req.wr;
	assign miss_detected = req_valid && !hit; // write misses fill too
	assign stall = fsm_busy || miss_detected;
	assign accept = req_valid && !stall;
	assign rd_hit = accept && cpu_req.rd;
	assign wr_hit = accept && cpu_req.wr; // only possible while the FSM is idle

	// ****************************************
	// blocks
	// ****************************************

	cache_tag_array u_tags (
		.clk(clk),
		.arst_n(arst_n),
		.lookup_addr(cpu_req.addr),
		.write_tag(write_tag),
		.fill_addr(base_addr),
		.hit(hit)
	);

	cache_fill_fsm u_fill (
		.clk(clk),
		.arst_n(arst_n),
		.miss_detected(miss_detected),
		.mem_data_valid(mem_rsp.valid),
		.miss_addr(cpu_req.addr),
		.fsm_busy(fsm_busy),
		.mem_read(mem_read),
		.mem_read_addr(mem_read_addr),
		.write_data_array(fill_we),
		.cache_write_block_offset(fill_offset),
		.write_tag_array(write_tag),
		.base_addr(base_addr)
	);

	// fill words land in the block being fetched, at the FSM's write offset
	assign fill_word_addr.tag = base_addr.tag;
	assign fill_word_addr.index = base_addr.index;
	assign fill_word_addr.offset = fill_offset;

	// fill and write hit never overlap, fill wins the mux anyway
	assign arr_we = fill_we || wr_hit;
	assign arr_waddr = fill_we ? fill_word_addr : cpu_req.addr;
	assign arr_wdata = fill_we ? mem_rsp.data : cpu_req.wdata;

	cache_data_array u_data (
		.clk(clk),
		.rd_en(rd_hit),
		.rd_addr(cpu_req.addr),
		.wr_en(arr_we),
		.wr_addr(arr_waddr),
		.wdata(arr_wdata),
		.rdata(rdata)
	);

	// ****************************************
	// outputs
	// ****************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= rd_hit; // lines up with the registered array read
		end
	end

	// memory sees fill reads while busy and write through when a write hits
	assign mem_req.rd = mem_read;
	assign mem_req.wr = wr_hit;
	assign mem_req.addr = mem_read ? mem_read_addr : cpu_req.addr;
	assign mem_req.wdata = cpu_req.wdata;

endmodule

/* source/cache_data_array.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"

module cache_data_array
	import dcache_pkg::*;
(
	input logic clk,
	input logic rd_en, // accepted read hit
	input cache_addr_t rd_addr,
	input logic wr_en, // fill word or write hit, never both
	input cache_addr_t wr_addr,
	input logic [`DATA_W-1:0] wdata,

	output logic [`DATA_W-1:0] rdata // registered, valid the cycle after rd_en
);

	logic [`DATA_W-1:0] words [`NUM_WORDS]; // all blocks, set major
	logic [`INDEX_W+`WORD_SEL_W-1:0] rd_idx; // set and word number of the read
	logic [`INDEX_W+`WORD_SEL_W-1:0] wr_idx; // set and word number of the write

	// ****************************************
	// word addressing
	// ****************************************

	// byte bit of the offset is dropped, words are always aligned
	assign rd_idx = {rd_addr.index, rd_addr.offset[`OFFSET_W-1:1]};
	assign wr_idx = {wr_addr.index, wr_addr.offset[`OFFSET_W-1:1]};

	// ****************************************
	// ports
	// ****************************************

	// single write port, the top level picks the source
	always_ff @(posedge clk) begin
		if (wr_en) begin
			words[wr_idx] <= wdata;
		end
	end

	// read register holds its value between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= words[rd_idx]; // old data if a write hits the same word, cannot happen here
		end
	end

endmodule

/* source/cache_tag_array.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"

module cache_tag_array
	import dcache_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input cache_addr_t lookup_addr, // address of the processor request
	input logic write_tag, // fill complete, store the tag and mark the set valid
	input cache_addr_t fill_addr, // block base of the fill

	output logic hit // stored tag matches and the set holds a valid block
);

	logic [`TAG_W-1:0] tags [`NUM_SETS]; // one tag per set
	logic [`NUM_SETS-1:0] valid; // one valid bit per set
	logic [`TAG_W-1:0] lookup_tag; // tag stored at the lookup index
	logic lookup_valid; // valid bit at the lookup index

	// ****************************************
	// storage
	// ****************************************

	// tag bits are meaningless until valid is set, so they keep whatever they power up with
	always_ff @(posedge clk) begin
		if (write_tag) begin
			tags[fill_addr.index] <= fill_addr.tag;
		end
	end

	// valid bits are the real state of the cache
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0; // empty cache after reset
		end else if (write_tag) begin
			valid[fill_addr.index] <= 1'b1; // sets are never invalidated, only replaced
		end
	end

	// ****************************************
	// lookup
	// ****************************************

	// combinational so a miss stalls the processor in the request cycle itself
	assign lookup_tag = tags[lookup_addr.index];
	assign lookup_valid = valid[lookup_addr.index];

	// the new tag is visible from the edge that wrote it, so a held request
	// turns into a hit in the cycle after the tag strobe
	assign hit = lookup_valid && (lookup_tag == lookup_addr.tag);

endmodule

/* source/cache_fill_fsm.sv */
`timescale 1ns/1ps
`include "dcache_consts.svh"

module cache_fill_fsm
	import dcache_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic miss_detected, // tag compare found no match for a live request
	input logic mem_data_valid, // a returning word is on the memory bus
	input cache_addr_t miss_addr, // address of the request that missed

	output logic fsm_busy, // high from the edge after the miss until the fill is done
	output logic mem_read, // one word read per cycle while high
	output cache_addr_t mem_read_addr, // block base plus the read offset
	output logic write_data_array, // store the returning word into the data array
	output logic [`OFFSET_W-1:0] cache_write_block_offset, // where that word goes
	output logic write_tag_array, // single cycle strobe once the block is complete
	output cache_addr_t base_addr // block aligned miss address
);

	fill_state_t state; // current state
	fill_state_t state_nxt; // state for the coming edge
	cache_addr_t base_q; // block base, latched when the fill starts
	logic [`OFFSET_W-1:0] rd_off; // byte offset of the next read to issue
	logic rd_done; // set by the carry out of the last read offset
	logic [`OFFSET_W-1:0] wr_off; // byte offset of the next word to arrive
	logic [`OFFSET_W:0] rd_sum; // read offset plus one word, with carry
	logic [`OFFSET_W:0] wr_sum; // write offset plus one word, with carry
	logic wr_carry; // the word arriving now is the last of the block

	// ****************************************
	// state register and next state
	// ****************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= FILL_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state; // hold unless something below moves us
		case (state)
			FILL_IDLE: begin
				if (miss_detected) begin
					state_nxt = FILL_BUSY; // start the block fill
				end
			end
			FILL_BUSY: begin
				// the eighth word ends the data phase, whatever the read side is doing
				if (write_data_array && wr_carry) begin
					state_nxt = FILL_TAG;
				end
			end
			FILL_TAG: state_nxt = FILL_IDLE; // tag goes in on this edge
			default: state_nxt = FILL_IDLE;
		endcase
	end

	// base address is taken only on entry, the processor holds its request anyway
	always_ff @(posedge clk) begin
		if (state == FILL_IDLE && miss_detected) begin
			base_q.tag <= miss_addr.tag;
			base_q.index <= miss_addr.index;
			base_q.offset <= '0; // align to the start of the block
		end
	end

	// ****************************************
	// read side, one request per cycle
	// ****************************************

	assign rd_sum = {1'b0, rd_off} + (`OFFSET_W+1)'(`WORD_BYTES);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_off <= '0;
			rd_done <= 1'b0;
		end else if (state != FILL_BUSY) begin
			rd_off <= '0; // cleared outside the busy phase so each fill starts at word 0
			rd_done <= 1'b0;
		end else if (mem_read) begin
			{rd_done, rd_off} <= rd_sum; // carry out of offset 14 stops the reads
		end
	end

	assign mem_read = (state == FILL_BUSY) && !rd_done;

	// base is aligned, so putting the counter in the offset field is the same as adding
	assign mem_read_addr.tag = base_q.tag;
	assign mem_read_addr.index = base_q.index;
	assign mem_read_addr.offset = rd_off;

	// ****************************************
	// write side, one step per returned word
	// ****************************************

	assign wr_sum = {1'b0, wr_off} + (`OFFSET_W+1)'(`WORD_BYTES);
	assign wr_carry = wr_sum[`OFFSET_W]; // last word of the block

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_off <= '0;
		end else if (state != FILL_BUSY) begin
			wr_off <= '0;
		end else if (write_data_array) begin
			wr_off <= wr_sum[`OFFSET_W-1:0]; // memory returns in order, so just count
		end
	end

	// words only count while a fill is running
	assign write_data_array = (state == FILL_BUSY) && mem_data_valid;
	assign cache_write_block_offset = wr_off;

	// ****************************************
	// status outputs
	// ****************************************

	assign fsm_busy = (state != FILL_IDLE); // covers the tag cycle too
	assign write_tag_array = (state == FILL_TAG); // exactly one cycle per fill
	assign base_addr = base_q;

endmodule

/* source/dcache_pkg.sv */
`include "dcache_consts.svh"

package dcache_pkg;

	// ****************************************
	// address layout
	// ****************************************

	// the tag sits on top, then the set index, then the byte offset
	typedef struct packed {
		logic [`TAG_W-1:0] tag; // compared against the stored tag
		logic [`INDEX_W-1:0] index; // picks the set
		logic [`OFFSET_W-1:0] offset; // byte inside the block
	} cache_addr_t;

	// ****************************************
	// processor and memory ports
	// ****************************************

	// request from the processor, held steady while the cache stalls
	typedef struct packed {
		logic rd; // read request level
		logic wr; // write request level
		cache_addr_t addr; // byte address of the word
		logic [`DATA_W-1:0] wdata; // store data, only meaningful with wr
	} cpu_req_t;

	// request toward main memory, one per cycle at most
	typedef struct packed {
		logic rd; // word read, part of a block fill
		logic wr; // write through of a write hit
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} mem_req_t;

	// one returning word, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic [`DATA_W-1:0] data;
	} mem_rsp_t;

	// states of the miss handler
	typedef enum logic [1:0] {
		FILL_IDLE, // waiting for a miss
		FILL_BUSY, // issuing reads and collecting words
		FILL_TAG // all words in, tag and valid bit get written
	} fill_state_t;

endpackage

/* source/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ****************************************
// address and word widths
// ****************************************
`define ADDR_W 16 // byte address from the processor
`define DATA_W 16 // one processor word

// ****************************************
// cache geometry, direct mapped
// ****************************************
`define TAG_W 7 // upper address bits kept per set
`define INDEX_W 5 // selects one of the sets
`define OFFSET_W 4 // byte offset inside a 16 byte block
`define NUM_SETS 32
`define WORDS_PER_BLOCK 8

// word select inside a block drops the byte bit of the offset
`define WORD_SEL_W 3
`define NUM_WORDS 256 // sets times words per block
`define WORD_BYTES 2 // the fill counters step by this much

`endif
